// File: source/interconnect_settings.svh
`ifndef INTERCONNECT_SETTINGS_SVH
`define INTERCONNECT_SETTINGS_SVH

// ========================================
// master side
// ========================================
`define NUM_MASTERS         4
`define MASTER_INDEX_WIDTH  2   // bits to encode a master index

// ========================================
// slave side
// ========================================
`define NUM_SLAVES          4
`define SLAVE_INDEX_WIDTH   2   // bits to encode a slave index

// request id as driven by a master, before the index tag
`define ID_WIDTH            1

`define ADDR_WIDTH          32

`endif

// File: source/axiAddrPkg.sv
`default_nettype none
`include "interconnect_settings.svh"

package axiAddrPkg;

	// field types of one address channel
	typedef logic [`ID_WIDTH-1:0]                      idT;
	typedef logic [`MASTER_INDEX_WIDTH+`ID_WIDTH-1:0]  masterIdT;  // master index above the id
	typedef logic [`ADDR_WIDTH-1:0]                    addrT;
	typedef logic [7:0]                                lenT;       // beats minus one
	typedef logic [2:0]                                sizeT;
	typedef logic [1:0]                                burstT;
	typedef logic [1:0]                                lockT;
	typedef logic [3:0]                                cacheT;
	typedef logic [2:0]                                protT;
	typedef logic [3:0]                                qosT;

	// request as presented by one master
	typedef struct packed {
		idT     id;
		addrT   addr;
		lenT    len;
		sizeT   size;
		burstT  burst;
		lockT   lock;
		cacheT  cache;
		protT   prot;
		qosT    qos;
	} masterReqT;

	// request as seen on the slave bus, id widened by the source index
	typedef struct packed {
		masterIdT  id;
		addrT      addr;
		lenT       len;
		sizeT      size;
		burstT     burst;
		lockT      lock;
		cacheT     cache;
		protT      prot;
		qosT       qos;
	} slaveReqT;

endpackage

`default_nettype wire

// File: source/routePkg.sv
`default_nettype none
`include "interconnect_settings.svh"

package routePkg;

	// encoded port numbers
	typedef logic [`MASTER_INDEX_WIDTH-1:0]  masterIndexT;
	typedef logic [`SLAVE_INDEX_WIDTH-1:0]   slaveIndexT;

	// one bit per port
	typedef logic [`NUM_MASTERS-1:0]  masterMaskT;
	typedef logic [`NUM_SLAVES-1:0]   slaveMaskT;

	// ========================================
	// route record pushed to the data-path fifo
	// ========================================
	typedef struct packed {
		axiAddrPkg::masterIdT  srcPort;   // tagged id, routes the response back
		slaveIndexT            destPort;  // slave the request went to
	} routeRecordT;

endpackage

`default_nettype wire

// File: source/requestSelect.sv
`timescale 1ns/1ps
`default_nettype none
`include "interconnect_settings.svh"

module requestSelect
(
	input  wire routePkg::masterIndexT                      i_requestorSelEnc,
	input  wire axiAddrPkg::masterReqT [`NUM_MASTERS-1:0]  i_masterReq,
	input  wire routePkg::slaveIndexT [`NUM_MASTERS-1:0]   i_targetSlave,
	output axiAddrPkg::slaveReqT                            o_selReq,
	output routePkg::slaveIndexT                            o_selTarget
);

	// every encodable index gets a slot, missing masters read as zero
	localparam int MASTER_SLOTS = 1 << `MASTER_INDEX_WIDTH;

	wire axiAddrPkg::masterReqT [MASTER_SLOTS-1:0]  paddedReq;
	wire routePkg::slaveIndexT [MASTER_SLOTS-1:0]   paddedTarget;
	axiAddrPkg::masterReqT                          grantedReq;

	// ========================================
	// pad the master arrays
	// ========================================
	genvar slot;
	generate
		for (slot = 0; slot < MASTER_SLOTS; slot++)
		begin : g_pad
			if (slot < `NUM_MASTERS)
			begin : g_live
				assign paddedReq[slot]    = i_masterReq[slot];
				assign paddedTarget[slot] = i_targetSlave[slot];
			end
			else
			begin : g_empty
				assign paddedReq[slot]    = '0;
				assign paddedTarget[slot] = '0;
			end
		end
	endgenerate

	// ========================================
	// pick the granted master
	// ========================================
	assign grantedReq  = paddedReq[i_requestorSelEnc];
	assign o_selTarget = paddedTarget[i_requestorSelEnc];  // decoded target of that master

	always_comb
	begin
		o_selReq.id    = {i_requestorSelEnc, grantedReq.id};  // tag for the response path
		o_selReq.addr  = grantedReq.addr;
		o_selReq.len   = grantedReq.len;
		o_selReq.size  = grantedReq.size;
		o_selReq.burst = grantedReq.burst;
		o_selReq.lock  = grantedReq.lock;
		o_selReq.cache = grantedReq.cache;
		o_selReq.prot  = grantedReq.prot;
		o_selReq.qos   = grantedReq.qos;
	end

endmodule

`default_nettype wire

// File: source/addrStage.sv
`timescale 1ns/1ps
`default_nettype none

module addrStage
(
	input  wire                        sysClk,
	input  wire                        sysReset,             // active low, async

	input  wire                        i_requestorSelValid,  // grant present this cycle
	input  wire axiAddrPkg::slaveReqT  i_selReq,
	input  wire routePkg::slaveIndexT  i_selTarget,
	input  wire                        i_slaveAccept,        // target took the request

	output axiAddrPkg::slaveReqT       o_slaveReq,           // broadcast to every slave
	output routePkg::slaveMaskT        o_slaveValid          // one-hot at the target
);

	routePkg::slaveMaskT  targetMask;
	logic                 raiseValid;

	// one-hot of the requested slave
	assign targetMask = routePkg::slaveMaskT'(1) << i_selTarget;

	// a request just accepted must not be presented again
	assign raiseValid = i_requestorSelValid & ~i_slaveAccept;

	// ========================================
	// slave address bus
	// ========================================
	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			o_slaveReq <= '0;
		end
		else if (i_requestorSelValid)
		begin
			o_slaveReq <= i_selReq;  // follow the granted master
		end
		// no grant, bus keeps the last request
	end

	// ========================================
	// per-slave valid
	// ========================================
	// rebuilt every cycle, so it drops the cycle after acceptance
	// and stays up under back-pressure while the grant is held
	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			o_slaveValid <= '0;
		end
		else if (raiseValid)
		begin
			o_slaveValid <= targetMask;
		end
		else
		begin
			o_slaveValid <= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/routeRecorder.sv
`timescale 1ns/1ps
`default_nettype none

module routeRecorder
(
	input  wire                         sysClk,
	input  wire                         sysReset,
	input  wire                         i_requestorSelValid,
	input  wire routePkg::masterIndexT  i_requestorSelEnc,
	input  wire routePkg::slaveIndexT   i_selTarget,
	input  wire axiAddrPkg::slaveReqT   i_slaveReq,    // registered bus, id only used here
	input  wire routePkg::slaveMaskT    i_slaveValid,
	input  wire routePkg::slaveMaskT    i_slaveReady,

	output logic                        o_slaveAccept,
	output logic                        o_arbEnable,
	output routePkg::masterMaskT        o_masterReady,
	output logic                        o_dataFifoWr,
	output routePkg::routeRecordT       o_routeRecord
);

	// ========================================
	// handshake completion
	// ========================================
	// valid is one-hot, so ready elsewhere drops out of the match
	assign o_slaveAccept = |(i_slaveReady & i_slaveValid);
	assign o_arbEnable   = o_slaveAccept;  // arbiter may move on

	always_comb
	begin
		o_masterReady = '0;
		if (i_requestorSelValid && o_slaveAccept)
		begin
			o_masterReady = routePkg::masterMaskT'(1) << i_requestorSelEnc;
		end
	end

	// ========================================
	// route record for the data fifo
	// ========================================
	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			o_dataFifoWr  <= 1'b0;
			o_routeRecord <= '0;
		end
		else
		begin
			o_dataFifoWr <= o_slaveAccept;  // one push per accepted request
			if (o_slaveAccept)
			begin
				o_routeRecord.srcPort  <= i_slaveReq.id;
				o_routeRecord.destPort <= i_selTarget;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/addrMuxController.sv
`timescale 1ns/1ps
`default_nettype none
`include "interconnect_settings.svh"

module addrMuxController
(
	input  wire                                             sysClk,
	input  wire                                             sysReset,

	// arbiter
	input  wire                                             i_requestorSelValid,
	input  wire routePkg::masterIndexT                      i_requestorSelEnc,
	input  wire routePkg::slaveIndexT [`NUM_MASTERS-1:0]   i_targetSlave,
	output routePkg::masterMaskT                            o_masterReady,
	output logic                                            o_arbEnable,

	// masters
	input  wire axiAddrPkg::masterReqT [`NUM_MASTERS-1:0]  i_masterReq,

	// slaves
	input  wire routePkg::slaveMaskT                        i_slaveReady,
	output routePkg::slaveMaskT                             o_slaveValid,
	output axiAddrPkg::slaveReqT                            o_slaveReq,

	// data-path fifo
	output logic                                            o_dataFifoWr,
	output routePkg::routeRecordT                           o_routeRecord
);

	axiAddrPkg::slaveReqT  selReq;       // tagged request of the granted master
	routePkg::slaveIndexT  selTarget;
	logic                  slaveAccept;  // valid/ready match on the target

	// ========================================
	// request selection
	// ========================================
	requestSelect u_requestSelect
	(
		.i_requestorSelEnc (i_requestorSelEnc),
		.i_masterReq       (i_masterReq),
		.i_targetSlave     (i_targetSlave),
		.o_selReq          (selReq),
		.o_selTarget       (selTarget)
	);

	// ========================================
	// registered slave bus
	// ========================================
	addrStage u_addrStage
	(
		.sysClk              (sysClk),
		.sysReset            (sysReset),
		.i_requestorSelValid (i_requestorSelValid),
		.i_selReq            (selReq),
		.i_selTarget         (selTarget),
		.i_slaveAccept       (slaveAccept),
		.o_slaveReq          (o_slaveReq),
		.o_slaveValid        (o_slaveValid)
	);

	// ========================================
	// handshake and route log
	// ========================================
	routeRecorder u_routeRecorder
	(
		.sysClk              (sysClk),
		.sysReset            (sysReset),
		.i_requestorSelValid (i_requestorSelValid),
		.i_requestorSelEnc   (i_requestorSelEnc),
		.i_selTarget         (selTarget),
		.i_slaveReq          (o_slaveReq),
		.i_slaveValid        (o_slaveValid),
		.i_slaveReady        (i_slaveReady),
		.o_slaveAccept       (slaveAccept),
		.o_arbEnable         (o_arbEnable),
		.o_masterReady       (o_masterReady),
		.o_dataFifoWr        (o_dataFifoWr),
		.o_routeRecord       (o_routeRecord)
	);

endmodule

`default_nettype wire

// File: tests/tbAddrMux.sv
`timescale 1ns/1ps
`default_nettype none
`include "interconnect_settings.svh"

module tbAddrMux;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 1;          // after the rising edge
	localparam int NUM_TXN     = 200;
	localparam int MAX_WAIT    = 3;          // target ready delay, in valid cycles
	localparam int NUM_CHECKS  = 8;
	localparam logic [31:0] SEED = 32'h75a0;
	// per transaction: grant cycle, waits, accept cycle and an idle gap
	localparam int WATCHDOG = (NUM_TXN * (MAX_WAIT + 6) + 100) * CLK_PERIOD;

	logic                                           sysClk;
	logic                                           sysReset;
	logic                                           selValid;
	routePkg::masterIndexT                          selEnc;
	routePkg::slaveIndexT [`NUM_MASTERS-1:0]        targetSlave;
	axiAddrPkg::masterReqT [`NUM_MASTERS-1:0]       masterReq;
	routePkg::slaveMaskT                            slaveReady;
	routePkg::masterMaskT                           masterReady;
	logic                                           arbEnable;
	routePkg::slaveMaskT                            slaveValid;
	axiAddrPkg::slaveReqT                           slaveReq;
	logic                                           dataFifoWr;
	routePkg::routeRecordT                          routeRecord;

	logic [31:0]  rngState;
	int           hits  [NUM_CHECKS];
	int           fails [NUM_CHECKS];

	// reference model of the registered stage and the route log
	axiAddrPkg::slaveReqT   expBus;
	routePkg::slaveMaskT    expValid;
	logic                   expAccept;
	logic                   expFifoWr;
	routePkg::routeRecordT  expRecord;

	addrMuxController dut_i
	(
		.sysClk              (sysClk),
		.sysReset            (sysReset),
		.i_requestorSelValid (selValid),
		.i_requestorSelEnc   (selEnc),
		.i_targetSlave       (targetSlave),
		.o_masterReady       (masterReady),
		.o_arbEnable         (arbEnable),
		.i_masterReq         (masterReq),
		.i_slaveReady        (slaveReady),
		.o_slaveValid        (slaveValid),
		.o_slaveReq          (slaveReq),
		.o_dataFifoWr        (dataFifoWr),
		.o_routeRecord       (routeRecord)
	);

	initial
	begin
		sysClk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) sysClk = ~sysClk;
		end
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// slave sees the master index above the master's own id
	function automatic axiAddrPkg::slaveReqT tagRequest(routePkg::masterIndexT m,
		axiAddrPkg::masterReqT r);
		axiAddrPkg::slaveReqT s;
		s.id    = {m, r.id};
		s.addr  = r.addr;
		s.len   = r.len;
		s.size  = r.size;
		s.burst = r.burst;
		s.lock  = r.lock;
		s.cache = r.cache;
		s.prot  = r.prot;
		s.qos   = r.qos;
		return s;
	endfunction

	task automatic step();
		@(posedge sysClk);
		#DRIVE_DELAY;
	endtask

	task automatic shuffleMasters();
		logic [63:0] raw;
		logic [31:0] r;
		for (int i = 0; i < `NUM_MASTERS; i++)
		begin
			raw = {nextRand(), nextRand()};
			masterReq[i] = raw[$bits(axiAddrPkg::masterReqT)-1:0];
			r = nextRand();
			targetSlave[i] = r[`SLAVE_INDEX_WIDTH-1:0];
		end
	endtask

	// stray ready on slaves that are not targeted
	function automatic routePkg::slaveMaskT strayReady(routePkg::slaveMaskT keepOff);
		logic [31:0] r;
		r = nextRand();
		if (r[5:4] == 2'b00)
			return r[`NUM_SLAVES-1:0] & ~keepOff;
		return '0;
	endfunction

	assign expAccept = |(slaveReady & expValid);

	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			expBus    <= '0;
			expValid  <= '0;
			expFifoWr <= 1'b0;
			expRecord <= '0;
		end
		else
		begin
			if (selValid)
				expBus <= tagRequest(selEnc, masterReq[selEnc]);
			expValid <= (selValid && !expAccept) ?
				routePkg::slaveMaskT'(1) << targetSlave[selEnc] : '0;
			expFifoWr <= expAccept;  // one push per accepted request
			if (expAccept)
			begin
				expRecord.srcPort  <= expBus.id;
				expRecord.destPort <= targetSlave[selEnc];
			end
		end
	end

	// ========================================
	// checks
	// ========================================
	// reset values, also on the first edge after release
	assert property (@(posedge sysClk) (!sysReset || !$past(sysReset)) |->
		(slaveValid == '0 && masterReady == '0 && !arbEnable && !dataFifoWr &&
		slaveReq == '0 && routeRecord == '0))
		hits[0]++;
	else
	begin
		fails[0]++;
		$display("outputs not in their reset state around reset");
	end

	assert property (@(posedge sysClk) disable iff (!sysReset) slaveValid == expValid)
		hits[1]++;
	else
	begin
		fails[1]++;
		$display("[FAIL] o_slaveValid expected %h actual %h",
			$sampled(expValid), $sampled(slaveValid));
	end

	assert property (@(posedge sysClk) disable iff (!sysReset) slaveReq == expBus)
		hits[2]++;
	else
	begin
		fails[2]++;
		$display("[FAIL] o_slaveReq expected %h actual %h", $sampled(expBus), $sampled(slaveReq));
	end

	assert property (@(posedge sysClk) disable iff (!sysReset) (selValid && expAccept) |->
		(arbEnable && masterReady == routePkg::masterMaskT'(1) << selEnc))
		hits[3]++;
	else
	begin
		fails[3]++;
		$display("[FAIL] o_masterReady expected %h actual %h",
			routePkg::masterMaskT'(1) << $sampled(selEnc), $sampled(masterReady));
	end

	// ready away from the target is ignored
	assert property (@(posedge sysClk) disable iff (!sysReset) !expAccept |->
		(!arbEnable && masterReady == '0))
		hits[4]++;
	else
	begin
		fails[4]++;
		$display("[FAIL] o_arbEnable expected 0 actual %h", $sampled(arbEnable));
	end

	assert property (@(posedge sysClk) disable iff (!sysReset) expFifoWr |->
		slaveValid == '0)
		hits[5]++;
	else
	begin
		fails[5]++;
		$display("[FAIL] o_slaveValid expected 0 actual %h", $sampled(slaveValid));
	end

	assert property (@(posedge sysClk) disable iff (!sysReset) dataFifoWr == expFifoWr)
		hits[6]++;
	else
	begin
		fails[6]++;
		$display("[FAIL] o_dataFifoWr expected %h actual %h",
			$sampled(expFifoWr), $sampled(dataFifoWr));
	end

	assert property (@(posedge sysClk) disable iff (!sysReset) expFifoWr |->
		routeRecord == expRecord)
		hits[7]++;
	else
	begin
		fails[7]++;
		$display("[FAIL] o_routeRecord expected %h actual %h",
			$sampled(expRecord), $sampled(routeRecord));
	end

	// ========================================
	// stimulus
	// ========================================
	function automatic int failTotal();
		int total;
		total = 0;
		for (int i = 0; i < NUM_CHECKS; i++)
			total += fails[i];
		return total;
	endfunction

	task automatic runTransfer();
		logic [31:0]          r;
		routePkg::slaveMaskT  tMask;
		int                   waits;
		int                   cnt;
		r = nextRand();
		step();
		selValid = 1'b1;
		selEnc   = r[1:0];
		shuffleMasters();
		targetSlave[selEnc] = r[3:2];
		tMask = routePkg::slaveMaskT'(1) << r[3:2];
		waits = int'(r[5:4]);
		cnt   = 0;
		slaveReady = strayReady(tMask);
		forever
		begin
			#DRIVE_DELAY;
			if (arbEnable)
				break;
			step();
			shuffleMasters();  // fields move, grant stays
			targetSlave[selEnc] = r[3:2];
			slaveReady = strayReady(tMask);
			if ((slaveValid & tMask) != '0)
			begin
				if (cnt >= waits)
					slaveReady = slaveReady | tMask;
				cnt++;
			end
		end
	endtask

	task automatic runIdle(int cycles);
		logic [31:0] r;
		for (int i = 0; i < cycles; i++)
		begin
			step();
			r = nextRand();
			selValid   = 1'b0;
			selEnc     = r[1:0];
			shuffleMasters();
			slaveReady = r[11:8];
		end
	endtask

	initial
	begin
		rngState    = SEED;
		sysReset    = 1'b0;
		selValid    = 1'b0;
		selEnc      = '0;
		targetSlave = '0;
		masterReq   = '0;
		slaveReady  = '0;
		repeat (8) @(posedge sysClk);
		#DRIVE_DELAY;
		sysReset = 1'b1;
		step();
		$display("reset test done, failures so far %0d", failTotal());

		for (int n = 0; n < NUM_TXN; n++)
		begin
			runTransfer();
			if (nextRand() % 3 == 0)
				runIdle(1);
		end
		$display("transfer test done, %0d transactions, failures so far %0d",
			NUM_TXN, failTotal());

		runIdle(20);
		$display("idle bus test done, failures so far %0d", failTotal());

		runIdle(2);
		$display("checks: %0d passed, %0d failed",
			hits[0] + hits[1] + hits[2] + hits[3] + hits[4] + hits[5] + hits[6] + hits[7],
			failTotal());
		if (failTotal() == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial
	begin
		#WATCHDOG;
		$display("timeout, the transfers did not finish in the expected time");
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/axiAddrPkg.sv
source/routePkg.sv
source/requestSelect.sv
source/addrStage.sv
source/routeRecorder.sv
source/addrMuxController.sv
tests/tbAddrMux.sv

// File: run_sim.sh
#!/bin/bash
# build and run the address mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
	-f sim.f \
	--top-module tbAddrMux \
	-Mdir obj_dir -o simAddrMux > build.log 2>&1 \
	&& ./obj_dir/simAddrMux > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "test passed" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }
